// ==== fft_feeder_pkg.sv ====
// ##################################################
// shared sample and config types for the FFT feeder
// DEFAULT_DEPTH must stay a power of two
// DEFAULT_FRAME_LEN must not exceed the buffer depth
// ##################################################
`default_nettype none

package fft_feeder_pkg;

    // sample word as seen by the FFT data channel
    localparam int SAMPLE_W = 16;                   // bits per sample

    typedef logic [SAMPLE_W-1:0] sample_t;          // one real sample

    // configuration channel of the FFT core
    localparam int CONFIG_W = 16;                   // config word width

    typedef logic [CONFIG_W-1:0] config_t;          // config word

    // frame defaults, overridden from the top level
    localparam int DEFAULT_FRAME_LEN = 64;          // samples per FFT frame

    localparam int DEFAULT_DEPTH = 128;             // ring buffer entries, power of two

    // bit 0 selects the transform direction
    // 1 is forward, 0 would be inverse
    localparam config_t DEFAULT_FFT_CONFIG = 16'h0001; // forward transform

endpackage : fft_feeder_pkg

`default_nettype wire

// ==== fft_config_ctrl.sv ====
// ##################################################
// sends one config beat to the FFT after reset
// config_done holds high until the next reset
// ##################################################
`timescale 1ns/1ps
`default_nettype none

module fft_config_ctrl #(
    parameter fft_feeder_pkg::config_t FFT_CONFIG = fft_feeder_pkg::DEFAULT_FFT_CONFIG
) (
    input  wire                             clk,
    input  wire                             reset_b,
    input  wire                             s_axis_config_tready,  // from FFT
    output logic                            s_axis_config_tvalid,  // to FFT
    output fft_feeder_pkg::config_t         s_axis_config_tdata,   // fixed word
    output logic                            config_done            // to frame_sender
);

    typedef enum logic [1:0] {
        IDLE       = 2'b00,   // wait for core to take config
        CONFIGURE  = 2'b01,   // present the config beat
        CONFIGURED = 2'b10    // done, stay here
    } state_t;

    state_t current_state, next_state;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            current_state <= IDLE;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            IDLE: begin
                if (s_axis_config_tready) next_state = CONFIGURE;  // core awake
            end
            CONFIGURE: begin
                if (s_axis_config_tready) next_state = CONFIGURED; // beat taken
            end
            CONFIGURED: next_state = CONFIGURED;                   // one shot only
            default:    next_state = IDLE;
        endcase
    end

    // valid held through the whole config state, not just one cycle
    assign s_axis_config_tvalid = (current_state == CONFIGURE);
    assign s_axis_config_tdata  = FFT_CONFIG;                      // constant word
    assign config_done          = (current_state == CONFIGURED);

endmodule : fft_config_ctrl

`default_nettype wire

// ==== sample_capture.sv ====
// ##################################################
// one write per strobe pulse, however long it lasts
// strobe must drop for at least one clock between pulses
// sample_data must be valid when the strobe rises
// ##################################################
`timescale 1ns/1ps
`default_nettype none

module sample_capture (
    input  wire                             clk,
    input  wire                             reset_b,
    input  wire                             sample_strobe,  // long pulse per sample
    input  wire fft_feeder_pkg::sample_t    sample_data,    // from sample source
    output logic                            wr_en,          // to ring buffer
    output fft_feeder_pkg::sample_t         wr_data         // to ring buffer
);

    logic strobe_q;    // strobe one clock ago
    logic strobe_rise; // first cycle of a pulse

    // previous strobe level for edge detect
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= sample_strobe;
        end
    end

    // high only on the first sampled cycle of the pulse,
    // the rest of the pulse is ignored like a hold-and-wait state
    assign strobe_rise = sample_strobe & ~strobe_q;

    // single-cycle write, one clock after the edge is seen
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= strobe_rise;
        end
    end

    // sample latched together with the edge
    always_ff @(posedge clk) begin
        if (strobe_rise) begin
            wr_data <= sample_data;   // held until the next pulse
        end
    end

endmodule : sample_capture

`default_nettype wire

// ==== sample_ring_buffer.sv ====
// ##################################################
// circular sample store, first-word-fall-through read
// DEPTH must be a power of two
// writes into a full buffer are lost, overflow is sticky
// ##################################################
`timescale 1ns/1ps
`default_nettype none

module sample_ring_buffer #(
    parameter int DEPTH = fft_feeder_pkg::DEFAULT_DEPTH
) (
    input  wire                             clk,
    input  wire                             reset_b,
    input  wire                             wr_en,      // from sample_capture
    input  wire fft_feeder_pkg::sample_t    wr_data,
    input  wire                             rd_en,      // pop, from frame_sender
    output fft_feeder_pkg::sample_t         rd_data,    // oldest sample
    output logic                            rd_valid,   // not empty
    output logic [$clog2(DEPTH+1)-1:0]      count,      // occupancy
    output logic                            overflow    // sticky, write lost
);

    localparam int PTR_W = $clog2(DEPTH);    // wraps naturally at DEPTH
    localparam int CNT_W = $clog2(DEPTH+1);  // holds 0..DEPTH

    fft_feeder_pkg::sample_t mem [DEPTH];    // sample storage

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             wr_ok;   // write accepted
    logic             rd_ok;   // read accepted

    assign full  = (count == CNT_W'(DEPTH));
    assign wr_ok = wr_en & ~full;       // full drops the write
    assign rd_ok = rd_en & rd_valid;    // no pop from empty

    // pointers and occupancy
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
            if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
            // read and write together cancel out
            count <= count + CNT_W'(wr_ok) - CNT_W'(rd_ok);
        end
    end

    // sticky overflow flag
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            overflow <= 1'b0;
        end else if (wr_en && full) begin
            overflow <= 1'b1;   // cleared only by reset
        end
    end

    // storage write port
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // fall-through read, head of queue always visible
    assign rd_data  = mem[rd_ptr];
    assign rd_valid = (count != '0);   // follows count by construction

endmodule : sample_ring_buffer

`default_nettype wire

// ==== frame_sender.sv ====
// ##################################################
// streams FRAME_LEN samples per frame to the FFT
// a frame starts only once it is fully buffered
// enable is sampled at frame start, frames always finish
// ##################################################
`timescale 1ns/1ps
`default_nettype none

module frame_sender #(
    parameter int FRAME_LEN = fft_feeder_pkg::DEFAULT_FRAME_LEN,
    parameter int DEPTH     = fft_feeder_pkg::DEFAULT_DEPTH
) (
    input  wire                             clk,
    input  wire                             reset_b,
    input  wire                             config_done,   // FFT ready for data
    input  wire                             enable,        // start new frames
    input  wire fft_feeder_pkg::sample_t    rd_data,       // buffer head
    input  wire                             rd_valid,
    input  wire [$clog2(DEPTH+1)-1:0]       count,         // buffer occupancy
    output logic                            rd_en,         // pop on accepted beat
    output fft_feeder_pkg::sample_t         s_axis_data_tdata,
    output logic                            s_axis_data_tvalid,
    output logic                            s_axis_data_tlast,
    input  wire                             s_axis_data_tready,
    output logic                            send_frame     // frame in progress
);

    localparam int CNT_W  = $clog2(DEPTH+1);
    localparam int BEAT_W = (FRAME_LEN > 1) ? $clog2(FRAME_LEN) : 1;

    typedef enum logic [1:0] {
        IDLE        = 2'b00,  // wait for a whole frame
        START_FRAME = 2'b01,  // announce the frame
        SENDING     = 2'b10   // stream the beats
    } state_t;

    state_t current_state, next_state;

    logic [BEAT_W-1:0] beat_cnt;      // beats accepted in this frame
    logic              frame_ready;   // whole frame sitting in the buffer
    logic              last_beat;
    logic              beat_xfer;     // data handshake

    assign frame_ready = (count >= CNT_W'(FRAME_LEN));
    assign last_beat   = (beat_cnt == BEAT_W'(FRAME_LEN - 1));
    assign beat_xfer   = s_axis_data_tvalid & s_axis_data_tready;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            current_state <= IDLE;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            IDLE: begin
                if (config_done && enable && frame_ready) next_state = START_FRAME;
            end
            START_FRAME: next_state = SENDING;        // always one cycle
            SENDING: begin
                if (beat_xfer && last_beat) next_state = IDLE; // tlast taken
            end
            default: next_state = IDLE;
        endcase
    end

    // beat index within the frame
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            beat_cnt <= '0;
        end else if (current_state != SENDING) begin
            beat_cnt <= '0;                    // fresh count per frame
        end else if (beat_xfer) begin
            beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
        end
    end

    // buffer head passes straight through, stable until popped
    assign s_axis_data_tdata  = rd_data;
    assign s_axis_data_tvalid = (current_state == SENDING) & rd_valid;
    assign s_axis_data_tlast  = (current_state == SENDING) & last_beat;
    assign rd_en              = beat_xfer;     // one pop per accepted beat

    // drops the cycle after the tlast handshake
    assign send_frame = (current_state == START_FRAME) || (current_state == SENDING);

endmodule : frame_sender

`default_nettype wire

// ==== fft_feeder_top.sv ====
// ##################################################
// front end feeding a streaming FFT core
// DEPTH must be a power of two and at least FRAME_LEN
// single channel, FFT result path not handled here
// ##################################################
`timescale 1ns/1ps
`default_nettype none

module fft_feeder_top #(
    parameter int                      FRAME_LEN  = fft_feeder_pkg::DEFAULT_FRAME_LEN,
    parameter int                      DEPTH      = fft_feeder_pkg::DEFAULT_DEPTH,
    parameter fft_feeder_pkg::config_t FFT_CONFIG = fft_feeder_pkg::DEFAULT_FFT_CONFIG
) (
    input  wire                             clk,
    input  wire                             reset_b,

    // sample source
    input  wire fft_feeder_pkg::sample_t    sample_data,
    input  wire                             sample_strobe,    // multi-cycle pulse

    input  wire                             enable,           // allow new frames

    // FFT config channel
    output fft_feeder_pkg::config_t         s_axis_config_tdata,
    output logic                            s_axis_config_tvalid,
    input  wire                             s_axis_config_tready,

    // FFT data channel
    output fft_feeder_pkg::sample_t         s_axis_data_tdata,
    output logic                            s_axis_data_tvalid,
    output logic                            s_axis_data_tlast,
    input  wire                             s_axis_data_tready,

    // status
    output logic                            config_done,
    output logic                            send_frame,
    output logic                            overflow
);

    logic                          wr_en;     // capture -> buffer
    fft_feeder_pkg::sample_t       wr_data;
    fft_feeder_pkg::sample_t       rd_data;   // buffer -> sender
    logic                          rd_valid;
    logic [$clog2(DEPTH+1)-1:0]    count;
    logic                          rd_en;     // sender -> buffer

    fft_config_ctrl #(
        .FFT_CONFIG (FFT_CONFIG)
    ) fft_config_ctrl_inst (
        .clk                  (clk),
        .reset_b              (reset_b),
        .s_axis_config_tready (s_axis_config_tready),
        .s_axis_config_tvalid (s_axis_config_tvalid),
        .s_axis_config_tdata  (s_axis_config_tdata),
        .config_done          (config_done)
    );

    sample_capture sample_capture_inst (
        .clk           (clk),
        .reset_b       (reset_b),
        .sample_strobe (sample_strobe),
        .sample_data   (sample_data),
        .wr_en         (wr_en),
        .wr_data       (wr_data)
    );

    sample_ring_buffer #(
        .DEPTH (DEPTH)
    ) sample_ring_buffer_inst (
        .clk      (clk),
        .reset_b  (reset_b),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .count    (count),
        .overflow (overflow)
    );

    frame_sender #(
        .FRAME_LEN (FRAME_LEN),
        .DEPTH     (DEPTH)
    ) frame_sender_inst (
        .clk                (clk),
        .reset_b            (reset_b),
        .config_done        (config_done),
        .enable             (enable),
        .rd_data            (rd_data),
        .rd_valid           (rd_valid),
        .count              (count),
        .rd_en              (rd_en),
        .s_axis_data_tdata  (s_axis_data_tdata),
        .s_axis_data_tvalid (s_axis_data_tvalid),
        .s_axis_data_tlast  (s_axis_data_tlast),
        .s_axis_data_tready (s_axis_data_tready),
        .send_frame         (send_frame)
    );

endmodule : fft_feeder_top

`default_nettype wire

// ==== tb_fft_feeder.sv ====
// ##################################################
// testbench for fft_feeder_top with FRAME_LEN 8, DEPTH 16
// FFT core modelled here without its result path
// ##################################################
`timescale 1ns/1ps
`default_nettype none

module tb_fft_feeder;

    localparam int FRAME_LEN = 8;
    localparam int DEPTH     = 16;
    localparam fft_feeder_pkg::config_t FFT_CONFIG = fft_feeder_pkg::DEFAULT_FFT_CONFIG;
    localparam int CFG_DELAY       = 60;                        // cycles before config tready
    localparam int TOTAL_BEATS     = 13 * FRAME_LEN + DEPTH;    // data beats over all tests
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20 + CFG_DELAY + 400;

    logic                    clk;
    logic                    reset_b;
    fft_feeder_pkg::sample_t sample_data;
    logic                    sample_strobe;
    logic                    enable;
    fft_feeder_pkg::config_t s_axis_config_tdata;
    logic                    s_axis_config_tvalid;
    logic                    s_axis_config_tready;
    fft_feeder_pkg::sample_t s_axis_data_tdata;
    logic                    s_axis_data_tvalid;
    logic                    s_axis_data_tlast;
    logic                    s_axis_data_tready;
    logic                    config_done;
    logic                    send_frame;
    logic                    overflow;

    fft_feeder_pkg::sample_t exp_q [$];   // pushed but not yet delivered
    logic [31:0] stim_state;              // sample values and strobe lengths
    logic [31:0] ready_state;             // data tready pattern
    bit          random_ready;            // 0 keeps data tready high
    bit          stall_mode;              // enable low so the buffer may fill
    int          stall_pushes;
    int          beat_count;
    int          tlast_count;
    int          config_beats;
    int          errors;
    int          checks;
    int          tests_run;
    int          test_start_errors;

    fft_feeder_top #(
        .FRAME_LEN  (FRAME_LEN),
        .DEPTH      (DEPTH),
        .FFT_CONFIG (FFT_CONFIG)
    ) fft_feeder_top_inst (
        .clk                  (clk),
        .reset_b              (reset_b),
        .sample_data          (sample_data),
        .sample_strobe        (sample_strobe),
        .enable               (enable),
        .s_axis_config_tdata  (s_axis_config_tdata),
        .s_axis_config_tvalid (s_axis_config_tvalid),
        .s_axis_config_tready (s_axis_config_tready),
        .s_axis_data_tdata    (s_axis_data_tdata),
        .s_axis_data_tvalid   (s_axis_data_tvalid),
        .s_axis_data_tlast    (s_axis_data_tlast),
        .s_axis_data_tready   (s_axis_data_tready),
        .config_done          (config_done),
        .send_frame           (send_frame),
        .overflow             (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 100 MHz
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // reference model for the config word and framing
    function automatic fft_feeder_pkg::config_t expected_config();
        return FFT_CONFIG;                          // the one word the core must see
    endfunction

    function automatic logic expected_tlast(input int beat_idx);
        return (beat_idx % FRAME_LEN) == (FRAME_LEN - 1);
    endfunction

    function automatic logic expected_overflow(input int pushes);
        return pushes > DEPTH;                      // only once a write found it full
    endfunction

    task automatic report_failure(input string what);
        $display("error at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic compare_sample(input string name, input fft_feeder_pkg::sample_t actual,
                                  input fft_feeder_pkg::sample_t expected);
        checks++;
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_config(input string name, input fft_feeder_pkg::config_t actual,
                                  input fft_feeder_pkg::config_t expected);
        checks++;
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_count(input string name, input int actual, input int expected);
        checks++;
        if (actual != expected) begin
            $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    // beats checked at the falling edge before the transfer edge
    always @(negedge clk) begin
        if (reset_b) begin
            if (s_axis_config_tvalid && s_axis_config_tready) begin
                config_beats++;
                compare_config("s_axis_config_tdata", s_axis_config_tdata, expected_config());
            end
            if (s_axis_data_tvalid && s_axis_data_tready) begin
                if (!config_done) report_failure("data beat accepted before config_done");
                if (exp_q.size() == 0) begin
                    report_failure("data beat accepted with no sample pending");
                end else begin
                    compare_sample("s_axis_data_tdata", s_axis_data_tdata, exp_q.pop_front());
                end
                compare_bit("s_axis_data_tlast", s_axis_data_tlast, expected_tlast(beat_count));
                compare_bit("send_frame", send_frame, 1'b1);
                beat_count++;
                if (s_axis_data_tlast) tlast_count++;
            end
        end
    end

    // FFT core model, drives both tready inputs
    initial begin
        int cfg_wait;
        cfg_wait             = 0;
        s_axis_config_tready = 1'b0;
        s_axis_data_tready   = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (!reset_b) begin
                cfg_wait = 0;
            end else if (cfg_wait < CFG_DELAY) begin
                cfg_wait++;                             // core still booting
            end else begin
                s_axis_config_tready = 1'b1;
            end
            if (random_ready) begin
                ready_state        = xorshift(ready_state);
                s_axis_data_tready = ready_state[0] | ready_state[2];   // ready ~3/4
            end else begin
                s_axis_data_tready = 1'b1;
            end
        end
    end

    // one sample per pulse with strobe high for hold cycles then low for one
    task automatic push_sample(input fft_feeder_pkg::sample_t value, input int hold);
        @(posedge clk);
        #1;
        sample_data   = value;
        sample_strobe = 1'b1;
        if (!stall_mode || stall_pushes < DEPTH) exp_q.push_back(value);  // full drops it
        if (stall_mode) stall_pushes++;
        @(posedge clk);                                 // rising edge seen here
        #1;
        sample_data = ~value;                           // junk for the rest of the pulse
        repeat (hold - 1) @(posedge clk);
        #1;
        sample_strobe = 1'b0;
    endtask

    task automatic push_block(input int n);
        fft_feeder_pkg::sample_t value;
        int hold;
        for (int i = 0; i < n; i++) begin
            stim_state = xorshift(stim_state);
            value      = fft_feeder_pkg::sample_t'(stim_state[31:16]);
            hold       = 2 + int'(stim_state[1:0]);     // 2 to 5 cycles
            push_sample(value, hold);
        end
    endtask

    task automatic set_enable(input logic value);
        @(posedge clk);
        #1;
        enable = value;
    endtask

    task automatic wait_config(input int max_cycles);
        int waited;
        waited = 0;
        while (!config_done && waited < max_cycles) begin
            @(posedge clk);
            waited++;
        end
        if (!config_done) report_failure("config_done never rose");
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || send_frame) && waited < DEPTH * 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0 || send_frame) report_failure("buffered frames were not delivered");
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
        tests_run++;
    endtask

    initial begin
        int b0;
        int t0;
        reset_b           = 1'b0;
        sample_data       = '0;
        sample_strobe     = 1'b0;
        enable            = 1'b0;
        stim_state        = 32'hf127_9970;
        ready_state       = xorshift(32'hf127_9970);   // own stream for tready
        random_ready      = 1'b0;
        stall_mode        = 1'b0;
        stall_pushes      = 0;
        beat_count        = 0;
        tlast_count       = 0;
        config_beats      = 0;
        errors            = 0;
        checks            = 0;
        tests_run         = 0;
        test_start_errors = 0;
        repeat (10) @(posedge clk);
        #1;
        reset_b = 1'b1;

        set_enable(1'b1);
        push_block(FRAME_LEN);                         // whole frame waits on config
        wait_config(CFG_DELAY + 20);
        wait_drained();
        repeat (4) @(posedge clk);
        compare_count("config beats", config_beats, 1);
        compare_bit("config_done", config_done, 1'b1);
        end_test("test 1 configuration");

        push_block(3 * FRAME_LEN);
        wait_drained();
        end_test("test 2 frame content and order");

        b0 = beat_count;
        t0 = tlast_count;
        push_block(2 * FRAME_LEN);
        wait_drained();
        compare_count("data beats", beat_count - b0, 2 * FRAME_LEN);
        compare_count("tlast beats", tlast_count - t0, 2);
        end_test("test 3 framing");

        random_ready = 1'b1;
        push_block(4 * FRAME_LEN);
        wait_drained();
        random_ready = 1'b0;
        end_test("test 4 back-pressure");

        set_enable(1'b0);
        stall_mode   = 1'b1;
        stall_pushes = 0;
        b0           = beat_count;
        push_block(2 * FRAME_LEN);                     // exactly fills the buffer
        repeat (20) @(posedge clk);
        @(negedge clk);
        compare_count("beats while disabled", beat_count - b0, 0);
        compare_bit("send_frame", send_frame, 1'b0);
        compare_bit("overflow", overflow, expected_overflow(stall_pushes));
        stall_mode = 1'b0;
        set_enable(1'b1);
        wait_drained();
        compare_count("beats after enable", beat_count - b0, 2 * FRAME_LEN);
        end_test("test 5 long strobes and enable gating");

        set_enable(1'b0);
        stall_mode   = 1'b1;
        stall_pushes = 0;
        b0           = beat_count;
        push_block(DEPTH + 3);                         // last three hit a full buffer
        repeat (3) @(posedge clk);
        @(negedge clk);
        compare_bit("overflow", overflow, expected_overflow(stall_pushes));
        stall_mode = 1'b0;
        set_enable(1'b1);
        wait_drained();
        repeat (2 * FRAME_LEN) @(posedge clk);
        @(negedge clk);
        compare_count("beats after overflow", beat_count - b0, DEPTH);
        push_block(FRAME_LEN);                         // stale entries would lead this frame
        wait_drained();
        compare_count("beats after refill", beat_count - b0, DEPTH + FRAME_LEN);
        end_test("test 6 overflow");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("error: watchdog ran out after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule : tb_fft_feeder

`default_nettype wire

// ==== fft_feeder.f ====
fft_feeder_pkg.sv
fft_config_ctrl.sv
sample_capture.sv
sample_ring_buffer.sv
frame_sender.sv
fft_feeder_top.sv
tb_fft_feeder.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds tb_fft_feeder with Verilator and runs it
# exit status is 1 when the log holds the fail message
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_fft_feeder \
    -f fft_feeder.f \
    -o sim_fft_feeder

./obj_dir/sim_fft_feeder > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run_sim: testbench reported a failure"
    exit 1
fi
echo "run_sim: no failure in the log"
